// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_uncore
RTL_TOP    ?= uncore_top
FILELIST   ?= list.f
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== cfg_regs.sv ====
module cfg_regs
  import uncore_pkg::*;
  import msg_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_msg_t cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_msg_t resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i,
  output logic     freeze_o
);

  logic                    cmd_take;
  logic                    wr_en;
  logic [offset_width-1:0] reg_offset;
  logic [data_width-1:0]   rd_data;
  logic                    resp_v_r;
  mem_msg_t                resp_r;
  logic                    freeze_r;
  logic [data_width-1:0]   npc_r;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_take    = cmd_v_i & cmd_ready_o;
  assign wr_en       = cmd_take & (cmd_i.header.op == e_mem_wr);
  assign reg_offset  = cmd_i.header.addr[offset_width-1:0];

  always_comb
  begin
    case (reg_offset)
      cfg_freeze_offset: rd_data = {{(data_width-1){1'b0}}, freeze_r};
      cfg_npc_offset:    rd_data = npc_r;
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_r <= 1'b0;
      freeze_r <= 1'b1;
      npc_r    <= boot_npc;
    end
    else
    begin
      if (cmd_take)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
      if (wr_en && reg_offset == cfg_freeze_offset)
        freeze_r <= cmd_i.data[0];
      if (wr_en && reg_offset == cfg_npc_offset)
        npc_r <= cmd_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_take)
      resp_r <= '{header: cmd_i.header, data: wr_en ? '0 : rd_data};
  end

  assign resp_o   = resp_r;
  assign resp_v_o = resp_v_r;
  assign freeze_o = freeze_r;

endmodule

// ==== clint_slice.sv ====
module clint_slice
  import uncore_pkg::*;
  import msg_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_msg_t cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_msg_t resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i,
  output logic     timer_irq_o,
  output logic     software_irq_o
);

  logic                    cmd_take;
  logic                    wr_en;
  logic [offset_width-1:0] reg_offset;
  logic [data_width-1:0]   rd_data;
  logic                    resp_v_r;
  mem_msg_t                resp_r;
  logic [data_width-1:0]   mtime_r;
  logic [data_width-1:0]   mtimecmp_r;
  logic                    msip_r;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_take    = cmd_v_i & cmd_ready_o;
  assign wr_en       = cmd_take & (cmd_i.header.op == e_mem_wr);
  assign reg_offset  = cmd_i.header.addr[offset_width-1:0];

  always_comb
  begin
    case (reg_offset)
      clint_msip_offset:     rd_data = {{(data_width-1){1'b0}}, msip_r};
      clint_mtimecmp_offset: rd_data = mtimecmp_r;
      clint_mtime_offset:    rd_data = mtime_r;
      default:               rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      resp_v_r   <= 1'b0;
      mtime_r    <= '0;
      mtimecmp_r <= '1;
      msip_r     <= 1'b0;
    end
    else
    begin
      if (cmd_take)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
      // A load of mtime replaces that cycle's tick
      if (wr_en && reg_offset == clint_mtime_offset)
        mtime_r <= cmd_i.data;
      else
        mtime_r <= mtime_r + 1'b1;
      if (wr_en && reg_offset == clint_mtimecmp_offset)
        mtimecmp_r <= cmd_i.data;
      if (wr_en && reg_offset == clint_msip_offset)
        msip_r <= cmd_i.data[0];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_take)
      resp_r <= '{header: cmd_i.header, data: wr_en ? '0 : rd_data};
  end

  assign resp_o         = resp_r;
  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = (mtime_r >= mtimecmp_r);
  assign software_irq_o = msip_r;

endmodule

// ==== list.f ====
uncore_pkg.sv
msg_pkg.sv
uncore_switch.sv
cfg_regs.sv
clint_slice.sv
loopback.sv
uncore_top.sv
tb_uncore.sv

// ==== loopback.sv ====
module loopback
  import uncore_pkg::*;
  import msg_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  mem_msg_t cmd_i,
  input  logic     cmd_v_i,
  output logic     cmd_ready_o,
  output mem_msg_t resp_o,
  output logic     resp_v_o,
  input  logic     resp_yumi_i
);

  logic        cmd_take;
  logic        resp_v_r;
  mem_header_t hdr_r;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_take    = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_r <= 1'b0;
    else if (cmd_take)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (cmd_take)
      hdr_r <= cmd_i.header;
  end

  // Unmapped space reads as zero
  assign resp_o   = '{header: hdr_r, data: {data_width{1'b0}}};
  assign resp_v_o = resp_v_r;

endmodule

// ==== msg_pkg.sv ====
package msg_pkg;

  import uncore_pkg::*;

  typedef enum logic [0:0]
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Size is log2 of the access width in bytes
  typedef struct packed
  {
    mem_op_e                 op;
    logic [paddr_width-1:0]  addr;
    logic [2:0]              size;
    logic [lce_id_width-1:0] lce_id;
  } mem_header_t;

  typedef struct packed
  {
    mem_header_t             header;
    logic [data_width-1:0]   data;
  } mem_msg_t;

endpackage

// ==== tb_uncore.sv ====
module tb_uncore
  import uncore_pkg::*;
  import msg_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_route = 500;
  localparam int num_prio  = 150;
  localparam int num_cfg   = 200;
  localparam int num_clint = 40;
  localparam int num_steer = 300;
  localparam int num_loop  = 60;
  // Ten cycles per transaction leaves room for random back-pressure
  localparam int max_cycles = 10 * (num_route + 3 * num_prio + num_cfg + num_clint
                                    + 2 * num_steer + num_loop) + 1500;

  localparam int route_io    = 0;
  localparam int route_mem   = 1;
  localparam int route_local = 2;

  logic                   clk_i;
  logic                   arst_n_i;
  mem_msg_t [num_req-1:0] proc_cmd_i;
  logic [num_req-1:0]     proc_cmd_v_i;
  logic [num_req-1:0]     proc_cmd_yumi_o;
  mem_msg_t [num_req-1:0] proc_resp_o;
  logic [num_req-1:0]     proc_resp_v_o;
  logic [num_req-1:0]     proc_resp_yumi_i;
  mem_msg_t               io_cmd_o;
  logic                   io_cmd_v_o;
  logic                   io_cmd_ready_and_i;
  mem_msg_t               io_resp_i;
  logic                   io_resp_v_i;
  logic                   io_resp_yumi_o;
  mem_msg_t               mem_cmd_o;
  logic                   mem_cmd_v_o;
  logic                   mem_cmd_ready_and_i;
  mem_msg_t               mem_resp_i;
  logic                   mem_resp_v_i;
  logic                   mem_resp_yumi_o;
  logic                   freeze_o;
  logic                   timer_irq_o;
  logic                   software_irq_o;

  integer seed;
  string  test_name;
  int     errors = 0;
  int     err_mark = 0;
  int     tests = 0;
  int     failed_tests = 0;
  int     cycles = 0;

  uncore_top UUT (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("Run stopped at the limit of %0d cycles, a handshake never completed",
               max_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic int unsigned rnd();
    return $random(seed);
  endfunction

  function automatic logic coin_flip();
    return 1'(rnd());
  endfunction

  function automatic mem_op_e pick_op();
    return (coin_flip() == 1'b1) ? e_mem_wr : e_mem_rd;
  endfunction

  // Routing rule of the address map
  function automatic int route_of(input logic [paddr_width-1:0] addr);
    logic [3:0] dev;
    dev = addr[23:20];
    if (addr[39:36] != 4'h0)
      return route_io;
    if (addr >= 40'h00_5000_0000)
      return route_mem;
    if (dev == boot_dev || dev == host_dev)
      return route_io;
    if (dev == cache_dev)
      return route_mem;
    return route_local;
  endfunction

  function automatic logic [paddr_width-1:0] local_addr(input logic [3:0] dev,
                                                        input logic [15:0] offset);
    return {16'h0000, dev, 4'h0, offset};
  endfunction

  function automatic mem_msg_t make_cmd(input int req, input mem_op_e op,
                                        input logic [paddr_width-1:0] addr,
                                        input logic [data_width-1:0] data);
    mem_msg_t m;
    m.header.op     = op;
    m.header.addr   = addr;
    m.header.size   = 3'(rnd());
    m.header.lce_id = 2'(req);
    m.data          = data;
    return m;
  endfunction

  function automatic int highest(input logic [num_req-1:0] mask);
    int idx;
    idx = 0;
    for (int i = 0; i < num_req; i++)
      if (mask[i])
        idx = i;
    return idx;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic value_error(input string what, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
    errors++;
    $display("[ERROR] %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
  endtask

  task automatic plain_error(input string msg);
    errors++;
    $display("[ERROR] %s: %s", test_name, msg);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors == err_mark)
      $display("%s: done, no errors", test_name);
    else
    begin
      failed_tests++;
      $display("%s: done, %0d errors", test_name, errors - err_mark);
    end
  endtask

  // One command through the switch and the response when a local slave owns it
  task automatic transact(input int req, input mem_msg_t cmd, output mem_msg_t resp);
    int   dst;
    logic exp_yumi;
    logic fired;
    logic got;
    logic first_wait;
    dst        = route_of(cmd.header.addr);
    resp       = '0;
    fired      = 1'b0;
    got        = 1'b0;
    first_wait = 1'b1;
    proc_cmd_i[req]   = cmd;
    proc_cmd_v_i[req] = 1'b1;
    while (!fired)
    begin
      io_cmd_ready_and_i  = coin_flip();
      mem_cmd_ready_and_i = coin_flip();
      #1;
      if (io_cmd_v_o !== 1'(dst == route_io))
        value_error("io_cmd_v_o", dst == route_io, io_cmd_v_o);
      if (mem_cmd_v_o !== 1'(dst == route_mem))
        value_error("mem_cmd_v_o", dst == route_mem, mem_cmd_v_o);
      if (dst == route_io && io_cmd_o !== cmd)
        value_error("io_cmd_o", cmd, io_cmd_o);
      if (dst == route_mem && mem_cmd_o !== cmd)
        value_error("mem_cmd_o", cmd, mem_cmd_o);
      case (dst)
        route_io:  exp_yumi = io_cmd_ready_and_i;
        route_mem: exp_yumi = mem_cmd_ready_and_i;
        default:   exp_yumi = 1'b1;
      endcase
      if (proc_cmd_yumi_o !== (3'(exp_yumi) << req))
        value_error("proc_cmd_yumi_o", 3'(exp_yumi) << req, proc_cmd_yumi_o);
      fired = proc_cmd_yumi_o[req];
      next_cycle();
    end
    proc_cmd_v_i[req] = 1'b0;
    if (dst == route_local)
    begin
      while (!got)
      begin
        proc_resp_yumi_i = 3'(rnd());
        #1;
        // A local slave answers in the cycle after it takes the command
        if (first_wait && proc_resp_v_o[req] !== 1'b1)
          plain_error("the local response was not valid one cycle after the command was taken");
        first_wait = 1'b0;
        if (proc_resp_v_o[req])
        begin
          if (proc_resp_o[req].header !== cmd.header)
            value_error("response header", cmd.header, proc_resp_o[req].header);
          got  = proc_resp_yumi_i[req];
          resp = proc_resp_o[req];
        end
        if ((proc_resp_v_o & ~(3'b001 << req)) != 3'b000)
          plain_error($sformatf("a response for requester %0d showed up on another port",
                                req));
        next_cycle();
      end
      proc_resp_yumi_i = '0;
    end
  endtask

  task automatic clint_op(input mem_op_e op, input logic [15:0] offset,
                          input logic [data_width-1:0] wdata, output mem_msg_t resp);
    int req;
    req = int'(rnd() % 3);
    transact(req, make_cmd(req, op, local_addr(clint_dev, offset), wdata), resp);
  endtask

  task automatic after_reset();
    begin_test("reset");
    #1;
    if (freeze_o !== 1'b1)
      value_error("freeze_o", 1, freeze_o);
    if (timer_irq_o !== 1'b0)
      value_error("timer_irq_o", 0, timer_irq_o);
    if (software_irq_o !== 1'b0)
      value_error("software_irq_o", 0, software_irq_o);
    if (proc_cmd_yumi_o !== '0)
      value_error("proc_cmd_yumi_o", 0, proc_cmd_yumi_o);
    if (proc_resp_v_o !== '0)
      value_error("proc_resp_v_o", 0, proc_resp_v_o);
    if (io_cmd_v_o !== 1'b0 || mem_cmd_v_o !== 1'b0)
      plain_error("an outgoing command valid is high after reset");
    if (io_resp_yumi_o !== 1'b0 || mem_resp_yumi_o !== 1'b0)
      plain_error("a response yumi is high after reset");
    next_cycle();
    end_test();
  endtask

  task automatic route_random();
    int                     req;
    logic [paddr_width-1:0] addr;
    mem_op_e                op;
    mem_msg_t               resp;
    begin_test("routing");
    for (int n = 0; n < num_route; n++)
    begin
      req = int'(rnd() % 3);
      case (rnd() % 3)
        0:       addr = 40'({rnd(), rnd()});
        1:       addr = {4'h0, 36'({rnd(), rnd()})};
        default: addr = {8'h00, 4'(rnd() % 5), 28'(rnd())};
      endcase
      op = pick_op();
      // Only reads go to cfg and clint so their reset state survives
      if (route_of(addr) == route_local && (addr[23:20] == cfg_dev || addr[23:20] == clint_dev))
        op = e_mem_rd;
      transact(req, make_cmd(req, op, addr, {rnd(), rnd()}), resp);
    end
    end_test();
  endtask

  task automatic grant_order();
    mem_msg_t [num_req-1:0] cmds;
    logic [num_req-1:0]     pending;
    logic [num_req-1:0]     fired;
    int                     top;
    begin_test("command priority");
    for (int n = 0; n < num_prio; n++)
    begin
      pending = 3'(rnd());
      if (pending == '0)
        pending = '1;
      // Bit 35 set with the hio bits clear lands in DRAM
      for (int i = 0; i < num_req; i++)
        cmds[i] = make_cmd(i, pick_op(), {4'h0, 1'b1, 35'({rnd(), rnd()})}, {rnd(), rnd()});
      proc_cmd_i   = cmds;
      proc_cmd_v_i = pending;
      while (pending != '0)
      begin
        mem_cmd_ready_and_i = coin_flip();
        io_cmd_ready_and_i  = coin_flip();
        #1;
        top = highest(pending);
        if (mem_cmd_v_o !== 1'b1 || io_cmd_v_o !== 1'b0)
          plain_error("DRAM command valid missing or I/O command valid raised");
        if (mem_cmd_o !== cmds[top])
          value_error("mem_cmd_o", cmds[top], mem_cmd_o);
        if (proc_cmd_yumi_o !== (3'(mem_cmd_ready_and_i) << top))
          value_error("proc_cmd_yumi_o", 3'(mem_cmd_ready_and_i) << top, proc_cmd_yumi_o);
        fired = proc_cmd_yumi_o & pending;
        next_cycle();
        pending      = pending & ~fired;
        proc_cmd_v_i = pending;
      end
    end
    end_test();
  endtask

  task automatic cfg_sequence();
    logic                  model_freeze;
    logic [data_width-1:0] model_npc;
    logic [15:0]           offset;
    logic [data_width-1:0] wdata;
    logic [data_width-1:0] exp_data;
    mem_op_e               op;
    mem_msg_t              resp;
    int                    req;
    int                    sel;
    begin_test("config registers");
    model_freeze = 1'b1;
    model_npc    = 64'h0000_0000_8000_0000;
    for (int n = 0; n < num_cfg; n++)
    begin
      req   = int'(rnd() % 3);
      sel   = int'(rnd() % 3);
      op    = pick_op();
      wdata = {rnd(), rnd()};
      case (sel)
        0:       offset = 16'h0000;
        1:       offset = 16'h0008;
        default: offset = 16'h0010;
      endcase
      if (op == e_mem_wr || sel == 2)
        exp_data = '0;
      else if (sel == 0)
        exp_data = 64'(model_freeze);
      else
        exp_data = model_npc;
      if (op == e_mem_wr && sel == 0)
        model_freeze = wdata[0];
      if (op == e_mem_wr && sel == 1)
        model_npc = wdata;
      transact(req, make_cmd(req, op, local_addr(cfg_dev, offset), wdata), resp);
      if (resp.data !== exp_data)
        value_error("cfg response data", exp_data, resp.data);
      if (freeze_o !== model_freeze)
        value_error("freeze_o", model_freeze, freeze_o);
    end
    end_test();
  endtask

  task automatic clint_behavior();
    mem_msg_t              resp;
    logic [data_width-1:0] wdata;
    logic [data_width-1:0] t_first;
    begin_test("clint");
    for (int n = 0; n < 8; n++)
    begin
      wdata = {rnd(), rnd()};
      clint_op(e_mem_wr, 16'h0000, wdata, resp);
      if (software_irq_o !== wdata[0])
        value_error("software_irq_o", wdata[0], software_irq_o);
      clint_op(e_mem_rd, 16'h0000, '0, resp);
      if (resp.data !== 64'(wdata[0]))
        value_error("msip read", 64'(wdata[0]), resp.data);
    end
    clint_op(e_mem_wr, 16'h4000, '0, resp);
    if (timer_irq_o !== 1'b1)
      value_error("timer_irq_o with mtimecmp zero", 1, timer_irq_o);
    clint_op(e_mem_rd, 16'h4000, '0, resp);
    if (resp.data !== '0)
      value_error("mtimecmp read", 0, resp.data);
    clint_op(e_mem_wr, 16'h4000, '1, resp);
    if (timer_irq_o !== 1'b0)
      value_error("timer_irq_o with mtimecmp all ones", 0, timer_irq_o);
    for (int n = 0; n < 8; n++)
    begin
      clint_op(e_mem_rd, 16'hbff8, '0, resp);
      t_first = resp.data;
      repeat (int'(rnd() % 16) + 1) next_cycle();
      clint_op(e_mem_rd, 16'hbff8, '0, resp);
      if (resp.data <= t_first)
        plain_error($sformatf("mtime did not advance, read %0d then %0d", t_first, resp.data));
    end
    wdata = 64'h0000_0100_0000_0000;
    clint_op(e_mem_wr, 16'hbff8, wdata, resp);
    clint_op(e_mem_rd, 16'hbff8, '0, resp);
    if (resp.data < wdata || resp.data > wdata + 200)
      plain_error($sformatf("mtime read %0h shortly after loading %0h", resp.data, wdata));
    end_test();
  endtask

  task automatic steer_responses();
    mem_msg_t mem_msg;
    mem_msg_t io_msg;
    mem_msg_t sel;
    logic     mem_v;
    logic     io_v;
    logic     mem_took;
    logic     io_took;
    int       kind;
    int       lce;
    begin_test("response steering");
    for (int n = 0; n < num_steer; n++)
    begin
      kind    = int'(rnd() % 3);
      mem_msg = make_cmd(int'(rnd() % 3), pick_op(), 40'({rnd(), rnd()}), {rnd(), rnd()});
      io_msg  = make_cmd(int'(rnd() % 3), pick_op(), 40'({rnd(), rnd()}), {rnd(), rnd()});
      mem_v   = (kind != 1);
      io_v    = (kind != 0);
      mem_resp_i   = mem_msg;
      io_resp_i    = io_msg;
      mem_resp_v_i = mem_v;
      io_resp_v_i  = io_v;
      while (mem_v || io_v)
      begin
        proc_resp_yumi_i = 3'(rnd());
        #1;
        // DRAM wins over I/O
        sel = mem_v ? mem_msg : io_msg;
        lce = int'(sel.header.lce_id);
        if (proc_resp_v_o !== (3'b001 << lce))
          value_error("proc_resp_v_o", 3'b001 << lce, proc_resp_v_o);
        if (proc_resp_o[lce] !== sel)
          value_error("proc_resp_o", sel, proc_resp_o[lce]);
        if (mem_resp_yumi_o !== (mem_v && proc_resp_yumi_i[lce]))
          value_error("mem_resp_yumi_o", mem_v && proc_resp_yumi_i[lce], mem_resp_yumi_o);
        if (io_resp_yumi_o !== (!mem_v && proc_resp_yumi_i[lce]))
          value_error("io_resp_yumi_o", !mem_v && proc_resp_yumi_i[lce], io_resp_yumi_o);
        mem_took = mem_resp_yumi_o;
        io_took  = io_resp_yumi_o;
        next_cycle();
        if (mem_took)
        begin
          mem_v        = 1'b0;
          mem_resp_v_i = 1'b0;
        end
        if (io_took)
        begin
          io_v        = 1'b0;
          io_resp_v_i = 1'b0;
        end
      end
    end
    proc_resp_yumi_i = '0;
    end_test();
  endtask

  task automatic unmapped_local();
    logic [3:0]             dev;
    logic [paddr_width-1:0] addr;
    mem_msg_t               resp;
    int                     req;
    begin_test("loopback");
    for (int n = 0; n < num_loop; n++)
    begin
      req  = int'(rnd() % 3);
      dev  = 4'(5 + rnd() % 11);
      addr = {8'h00, 4'(rnd() % 5), 4'(rnd()), dev, 20'(rnd())};
      transact(req, make_cmd(req, pick_op(), addr, {rnd(), rnd()}), resp);
      if (resp.data !== '0)
        value_error("loopback data", 0, resp.data);
    end
    end_test();
  endtask

  initial
  begin
    seed                = 32'hb7496680;
    clk_i               = 1'b0;
    arst_n_i            = 1'b0;
    proc_cmd_i          = '0;
    proc_cmd_v_i        = '0;
    proc_resp_yumi_i    = '0;
    io_cmd_ready_and_i  = 1'b0;
    mem_cmd_ready_and_i = 1'b0;
    io_resp_i           = '0;
    io_resp_v_i         = 1'b0;
    mem_resp_i          = '0;
    mem_resp_v_i        = 1'b0;
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    after_reset();
    route_random();
    grant_order();
    cfg_sequence();
    clint_behavior();
    steer_responses();
    unmapped_local();
    $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== uncore_pkg.sv ====
package uncore_pkg;

  localparam int paddr_width   = 40;
  localparam int data_width    = 64;
  localparam int lce_id_width  = 2;
  localparam int num_req       = 3;
  localparam int num_dst       = 5;
  localparam int num_local     = 3;
  localparam int hio_width     = 4;
  localparam int dev_width     = 4;
  localparam int dev_lsb       = 20;
  localparam int offset_width  = 16;
  localparam int req_idx_width = $clog2(num_req);
  localparam int dst_idx_width = $clog2(num_dst);

  // Addresses below this are local devices
  localparam logic [paddr_width-1:0] local_limit = 40'h00_5000_0000;

  localparam logic [dev_width-1:0] boot_dev  = 4'd0;
  localparam logic [dev_width-1:0] host_dev  = 4'd1;
  localparam logic [dev_width-1:0] cfg_dev   = 4'd2;
  localparam logic [dev_width-1:0] clint_dev = 4'd3;
  localparam logic [dev_width-1:0] cache_dev = 4'd4;

  // Switch destinations, a higher index wins on the response side
  localparam int dst_cfg   = 0;
  localparam int dst_clint = 1;
  localparam int dst_io    = 2;
  localparam int dst_mem   = 3;
  localparam int dst_loop  = 4;

  // Slots of the local slaves on the switch
  localparam int local_cfg   = 0;
  localparam int local_clint = 1;
  localparam int local_loop  = 2;

  localparam logic [offset_width-1:0] cfg_freeze_offset     = 16'h0000;
  localparam logic [offset_width-1:0] cfg_npc_offset        = 16'h0008;
  localparam logic [offset_width-1:0] clint_msip_offset     = 16'h0000;
  localparam logic [offset_width-1:0] clint_mtimecmp_offset = 16'h4000;
  localparam logic [offset_width-1:0] clint_mtime_offset    = 16'hbff8;

  localparam logic [data_width-1:0] boot_npc = 64'h0000_0000_8000_0000;

endpackage

// ==== uncore_switch.sv ====
module uncore_switch
  import uncore_pkg::*;
  import msg_pkg::*;
(
  input  mem_msg_t [num_req-1:0]   proc_cmd_i,
  input  logic [num_req-1:0]       proc_cmd_v_i,
  output logic [num_req-1:0]       proc_cmd_yumi_o,
  output mem_msg_t [num_req-1:0]   proc_resp_o,
  output logic [num_req-1:0]       proc_resp_v_o,
  input  logic [num_req-1:0]       proc_resp_yumi_i,

  output mem_msg_t                 io_cmd_o,
  output logic                     io_cmd_v_o,
  input  logic                     io_cmd_ready_and_i,
  output mem_msg_t                 mem_cmd_o,
  output logic                     mem_cmd_v_o,
  input  logic                     mem_cmd_ready_and_i,
  input  mem_msg_t                 io_resp_i,
  input  logic                     io_resp_v_i,
  output logic                     io_resp_yumi_o,
  input  mem_msg_t                 mem_resp_i,
  input  logic                     mem_resp_v_i,
  output logic                     mem_resp_yumi_o,

  output mem_msg_t                 dev_cmd_o,
  output logic [num_local-1:0]     dev_cmd_v_o,
  input  logic [num_local-1:0]     dev_cmd_ready_i,
  input  mem_msg_t [num_local-1:0] dev_resp_i,
  input  logic [num_local-1:0]     dev_resp_v_i,
  output logic [num_local-1:0]     dev_resp_yumi_o
);

  logic [req_idx_width-1:0] cmd_idx;
  logic                     cmd_any;
  mem_msg_t                 cmd_sel;
  logic [paddr_width-1:0]   cmd_addr;
  logic [dev_width-1:0]     cmd_dev;
  logic [num_dst-1:0]       dst_sel;
  logic [num_dst-1:0]       dst_v;
  logic [num_dst-1:0]       dst_ready;
  logic                     cmd_fire;

  mem_msg_t [num_dst-1:0]   resp_src;
  logic [num_dst-1:0]       resp_v;
  logic [dst_idx_width-1:0] resp_idx;
  mem_msg_t                 resp_sel;
  logic                     resp_take;
  logic [num_dst-1:0]       resp_yumi;

  // Highest valid requester wins
  always_comb
  begin
    cmd_idx = '0;
    cmd_any = 1'b0;
    for (int i = 0; i < num_req; i++)
    begin
      if (proc_cmd_v_i[i])
      begin
        cmd_idx = req_idx_width'(i);
        cmd_any = 1'b1;
      end
    end
  end

  assign cmd_sel  = proc_cmd_i[cmd_idx];
  assign cmd_addr = cmd_sel.header.addr;
  assign cmd_dev  = cmd_addr[dev_lsb +: dev_width];

  always_comb
  begin
    dst_sel = '0;
    if (|cmd_addr[paddr_width-1 -: hio_width])
      dst_sel[dst_io] = 1'b1;
    else if (cmd_addr >= local_limit)
      dst_sel[dst_mem] = 1'b1;
    else
    begin
      case (cmd_dev)
        cfg_dev:            dst_sel[dst_cfg]   = 1'b1;
        clint_dev:          dst_sel[dst_clint] = 1'b1;
        boot_dev, host_dev: dst_sel[dst_io]    = 1'b1;
        cache_dev:          dst_sel[dst_mem]   = 1'b1;
        default:            dst_sel[dst_loop]  = 1'b1;
      endcase
    end
  end

  assign dst_ready[dst_cfg]   = dev_cmd_ready_i[local_cfg];
  assign dst_ready[dst_clint] = dev_cmd_ready_i[local_clint];
  assign dst_ready[dst_io]    = io_cmd_ready_and_i;
  assign dst_ready[dst_mem]   = mem_cmd_ready_and_i;
  assign dst_ready[dst_loop]  = dev_cmd_ready_i[local_loop];

  assign dst_v    = dst_sel & {num_dst{cmd_any}};
  assign cmd_fire = |(dst_v & dst_ready);

  always_comb
  begin
    proc_cmd_yumi_o          = '0;
    proc_cmd_yumi_o[cmd_idx] = cmd_fire;
  end

  // One command bus fans out, the valids pick the taker
  assign io_cmd_o   = cmd_sel;
  assign mem_cmd_o  = cmd_sel;
  assign dev_cmd_o  = cmd_sel;
  assign io_cmd_v_o  = dst_v[dst_io];
  assign mem_cmd_v_o = dst_v[dst_mem];
  assign dev_cmd_v_o[local_cfg]   = dst_v[dst_cfg];
  assign dev_cmd_v_o[local_clint] = dst_v[dst_clint];
  assign dev_cmd_v_o[local_loop]  = dst_v[dst_loop];

  assign resp_src[dst_cfg]   = dev_resp_i[local_cfg];
  assign resp_src[dst_clint] = dev_resp_i[local_clint];
  assign resp_src[dst_io]    = io_resp_i;
  assign resp_src[dst_mem]   = mem_resp_i;
  assign resp_src[dst_loop]  = dev_resp_i[local_loop];

  assign resp_v[dst_cfg]   = dev_resp_v_i[local_cfg];
  assign resp_v[dst_clint] = dev_resp_v_i[local_clint];
  assign resp_v[dst_io]    = io_resp_v_i;
  assign resp_v[dst_mem]   = mem_resp_v_i;
  assign resp_v[dst_loop]  = dev_resp_v_i[local_loop];

  // Loopback first, cfg last
  always_comb
  begin
    resp_idx = '0;
    for (int d = 0; d < num_dst; d++)
    begin
      if (resp_v[d])
        resp_idx = dst_idx_width'(d);
    end
  end

  assign resp_sel = resp_src[resp_idx];

  // Steer by lce_id
  always_comb
  begin
    for (int i = 0; i < num_req; i++)
    begin
      proc_resp_o[i]   = resp_sel;
      proc_resp_v_o[i] = (|resp_v) && (resp_sel.header.lce_id == lce_id_width'(i));
    end
  end

  // An lce_id with no requester is never taken
  assign resp_take = |(proc_resp_v_o & proc_resp_yumi_i);

  always_comb
  begin
    resp_yumi           = '0;
    resp_yumi[resp_idx] = resp_take;
  end

  assign io_resp_yumi_o  = resp_yumi[dst_io];
  assign mem_resp_yumi_o = resp_yumi[dst_mem];
  assign dev_resp_yumi_o[local_cfg]   = resp_yumi[dst_cfg];
  assign dev_resp_yumi_o[local_clint] = resp_yumi[dst_clint];
  assign dev_resp_yumi_o[local_loop]  = resp_yumi[dst_loop];

endmodule

// ==== uncore_top.sv ====
module uncore_top
  import uncore_pkg::*;
  import msg_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  mem_msg_t [num_req-1:0] proc_cmd_i,
  input  logic [num_req-1:0]     proc_cmd_v_i,
  output logic [num_req-1:0]     proc_cmd_yumi_o,
  output mem_msg_t [num_req-1:0] proc_resp_o,
  output logic [num_req-1:0]     proc_resp_v_o,
  input  logic [num_req-1:0]     proc_resp_yumi_i,

  output mem_msg_t               io_cmd_o,
  output logic                   io_cmd_v_o,
  input  logic                   io_cmd_ready_and_i,
  input  mem_msg_t               io_resp_i,
  input  logic                   io_resp_v_i,
  output logic                   io_resp_yumi_o,

  output mem_msg_t               mem_cmd_o,
  output logic                   mem_cmd_v_o,
  input  logic                   mem_cmd_ready_and_i,
  input  mem_msg_t               mem_resp_i,
  input  logic                   mem_resp_v_i,
  output logic                   mem_resp_yumi_o,

  output logic                   freeze_o,
  output logic                   timer_irq_o,
  output logic                   software_irq_o
);

  mem_msg_t                 dev_cmd;
  logic [num_local-1:0]     dev_cmd_v;
  logic [num_local-1:0]     dev_cmd_ready;
  mem_msg_t [num_local-1:0] dev_resp;
  logic [num_local-1:0]     dev_resp_v;
  logic [num_local-1:0]     dev_resp_yumi;

  uncore_switch sw
  (
    .proc_cmd_i          (proc_cmd_i),
    .proc_cmd_v_i        (proc_cmd_v_i),
    .proc_cmd_yumi_o     (proc_cmd_yumi_o),
    .proc_resp_o         (proc_resp_o),
    .proc_resp_v_o       (proc_resp_v_o),
    .proc_resp_yumi_i    (proc_resp_yumi_i),
    .io_cmd_o            (io_cmd_o),
    .io_cmd_v_o          (io_cmd_v_o),
    .io_cmd_ready_and_i  (io_cmd_ready_and_i),
    .mem_cmd_o           (mem_cmd_o),
    .mem_cmd_v_o         (mem_cmd_v_o),
    .mem_cmd_ready_and_i (mem_cmd_ready_and_i),
    .io_resp_i           (io_resp_i),
    .io_resp_v_i         (io_resp_v_i),
    .io_resp_yumi_o      (io_resp_yumi_o),
    .mem_resp_i          (mem_resp_i),
    .mem_resp_v_i        (mem_resp_v_i),
    .mem_resp_yumi_o     (mem_resp_yumi_o),
    .dev_cmd_o           (dev_cmd),
    .dev_cmd_v_o         (dev_cmd_v),
    .dev_cmd_ready_i     (dev_cmd_ready),
    .dev_resp_i          (dev_resp),
    .dev_resp_v_i        (dev_resp_v),
    .dev_resp_yumi_o     (dev_resp_yumi)
  );

  cfg_regs cfg
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_i       (dev_cmd),
    .cmd_v_i     (dev_cmd_v[local_cfg]),
    .cmd_ready_o (dev_cmd_ready[local_cfg]),
    .resp_o      (dev_resp[local_cfg]),
    .resp_v_o    (dev_resp_v[local_cfg]),
    .resp_yumi_i (dev_resp_yumi[local_cfg]),
    .freeze_o    (freeze_o)
  );

  clint_slice clint
  (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cmd_i          (dev_cmd),
    .cmd_v_i        (dev_cmd_v[local_clint]),
    .cmd_ready_o    (dev_cmd_ready[local_clint]),
    .resp_o         (dev_resp[local_clint]),
    .resp_v_o       (dev_resp_v[local_clint]),
    .resp_yumi_i    (dev_resp_yumi[local_clint]),
    .timer_irq_o    (timer_irq_o),
    .software_irq_o (software_irq_o)
  );

  loopback lpbk
  (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_i       (dev_cmd),
    .cmd_v_i     (dev_cmd_v[local_loop]),
    .cmd_ready_o (dev_cmd_ready[local_loop]),
    .resp_o      (dev_resp[local_loop]),
    .resp_v_o    (dev_resp_v[local_loop]),
    .resp_yumi_i (dev_resp_yumi[local_loop])
  );

endmodule
